// ==== spi_hub.f ====
source/spi_hub_pkg.sv
source/host_bus_if.sv
source/spi_slave.sv
source/reg_bank.sv
source/data_fifo.sv
source/spi_hub.sv
test/spi_hub_props.sv
test/tb_spi_hub.sv

// ==== Makefile ====
TOP := tb_spi_hub

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -f spi_hub.f

run: build
	-./obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	grep -q -F '*** TEST PASSED ***' sim.log

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/100ps \
		--top-module $(TOP) -f spi_hub.f

clean:
	rm -rf obj_dir sim.log

// ==== test/tb_spi_hub.sv ====
//************************************************************
// spi_hub testbench: directed mode 0 SPI bursts against the
// register map, data FIFO and interrupt level
//************************************************************
module tb_spi_hub;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int DW = spi_hub_pkg::DATA_W;
	localparam int DEPTH = 8;
	localparam int IRQ_WAIT = 64;

	logic SPI_SCLK;
	logic int_rst_n;
	logic spi_ss_n;
	logic spi_mosi;
	logic spi_miso;
	logic irq;

	int seed;
	int err_cnt;
	int chk_cnt;
	int test_cnt;
	// one transaction on the wire, and the payload of a burst
	logic [DW-1:0] tx_q [$];
	logic [DW-1:0] rx_q [$];
	logic [DW-1:0] data_q [$];
	// expected scratch contents
	logic [DW-1:0] scratch_model [$];

	spi_hub #(
		.FIFO_DEPTH (DEPTH)
	) dut0 (
		.SPI_SCLK  (SPI_SCLK),
		.int_rst_n (int_rst_n),
		.spi_ss_n  (spi_ss_n),
		.spi_mosi  (spi_mosi),
		.spi_miso  (spi_miso),
		.irq       (irq)
	);

	always #20 SPI_SCLK = ~SPI_SCLK;

	// command byte, direction on top
	function automatic logic [DW-1:0] make_cmd(input logic wr,
		input logic [spi_hub_pkg::ADDR_W-1:0] addr);
		spi_hub_pkg::spi_cmd_u cmd;
		cmd.f.wr = wr;
		cmd.f.addr = addr;
		return cmd.raw;
	endfunction

	// mosi changes on falling edges, miso captured on rising edges
	task automatic spi_xfer();
		logic [DW-1:0] cur;
		logic [DW-1:0] rx_byte;
		rx_q.delete();
		rx_byte = '0;
		foreach (tx_q[i]) begin
			cur = tx_q[i];
			repeat (DW) begin
				@(negedge SPI_SCLK);
				spi_ss_n = 1'b0;
				spi_mosi = cur[DW-1];
				cur = cur << 1;
				@(posedge SPI_SCLK);
				rx_byte = {rx_byte[DW-2:0], spi_miso};
			end
			rx_q.push_back(rx_byte);
		end
		@(negedge SPI_SCLK);
		spi_ss_n = 1'b1;
		spi_mosi = 1'b0;
		// idle time also lets the trailing write land
		repeat (4) @(negedge SPI_SCLK);
	endtask

	task automatic write_burst(input logic [spi_hub_pkg::ADDR_W-1:0] addr);
		tx_q.delete();
		tx_q.push_back(make_cmd(1'b1, addr));
		foreach (data_q[i]) begin
			tx_q.push_back(data_q[i]);
		end
		spi_xfer();
	endtask

	// data starts at the third byte, after command and dummy
	task automatic read_burst(input logic [spi_hub_pkg::ADDR_W-1:0] addr, input int n);
		tx_q.delete();
		tx_q.push_back(make_cmd(1'b0, addr));
		repeat (n + 1) tx_q.push_back(DW'(0));
		spi_xfer();
		data_q.delete();
		for (int i = 2; i < rx_q.size(); i++) begin
			data_q.push_back(rx_q[i]);
		end
	endtask

	task automatic write_one(input logic [spi_hub_pkg::ADDR_W-1:0] addr,
		input logic [DW-1:0] value);
		data_q.delete();
		data_q.push_back(value);
		write_burst(addr);
	endtask

	task automatic read_one(input logic [spi_hub_pkg::ADDR_W-1:0] addr,
		output logic [DW-1:0] value);
		read_burst(addr, 1);
		value = data_q[0];
	endtask

	task automatic check_byte(input string name, input logic [DW-1:0] exp,
		input logic [DW-1:0] act);
		chk_cnt++;
		if (act !== exp) begin
			$display("[ERROR] %0t %s expected %02h got %02h", $time, name, exp, act);
			err_cnt++;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		chk_cnt++;
		if (act !== exp) begin
			$display("[ERROR] %0t %s expected %0b got %0b", $time, name, exp, act);
			err_cnt++;
		end
	endtask

	// irq is a registered level, poll it on falling edges
	task automatic wait_irq(input logic level);
		int n;
		n = 0;
		while (irq !== level && n < IRQ_WAIT) begin
			@(negedge SPI_SCLK);
			n++;
		end
		if (irq !== level) begin
			$display("timeout: irq did not become %0b within %0d cycles", level, IRQ_WAIT);
			err_cnt++;
		end
	endtask

	task automatic finish_test(input string name, input int err_before);
		test_cnt++;
		if (err_cnt == err_before) begin
			$display("test %0d %s: ok", test_cnt, name);
		end else begin
			$display("test %0d %s: %0d errors", test_cnt, name, err_cnt - err_before);
		end
	endtask

	task automatic test_dev_id();
		int err0;
		logic [DW-1:0] v;
		err0 = err_cnt;
		read_one(spi_hub_pkg::DEV_ID_ADDR, v);
		check_byte("device_id", 8'hA5, v);
		finish_test("device id", err0);
	endtask

	task automatic test_scratch();
		int err0;
		err0 = err_cnt;
		scratch_model.delete();
		repeat (spi_hub_pkg::SCRATCH_N) scratch_model.push_back(DW'($random(seed)));
		data_q = scratch_model;
		write_burst(spi_hub_pkg::SCRATCH_BASE);
		read_burst(spi_hub_pkg::SCRATCH_BASE, spi_hub_pkg::SCRATCH_N);
		foreach (scratch_model[i]) begin
			check_byte("scratch", scratch_model[i], data_q[i]);
		end
		finish_test("scratch burst", err0);
	endtask

	task automatic test_fifo_burst();
		int err0;
		logic [DW-1:0] v;
		logic [DW-1:0] sent [$];
		err0 = err_cnt;
		data_q.delete();
		repeat (5) data_q.push_back(DW'($random(seed)));
		sent = data_q;
		// address holds on the data port, all five land in the fifo
		write_burst(spi_hub_pkg::FIFO_DATA_ADDR);
		read_one(spi_hub_pkg::FIFO_STAT_ADDR, v);
		check_byte("fifo_stat", 8'h05, v);
		read_burst(spi_hub_pkg::FIFO_DATA_ADDR, 5);
		foreach (sent[i]) begin
			check_byte("fifo_data", sent[i], data_q[i]);
		end
		read_one(spi_hub_pkg::FIFO_STAT_ADDR, v);
		check_byte("fifo_stat", 8'h00, v);
		finish_test("fifo burst", err0);
	endtask

	task automatic test_fifo_full();
		int err0;
		logic [DW-1:0] v;
		logic [DW-1:0] sent [$];
		err0 = err_cnt;
		data_q.delete();
		repeat (DEPTH + 2) data_q.push_back(DW'($random(seed)));
		sent = data_q;
		write_burst(spi_hub_pkg::FIFO_DATA_ADDR);
		// full flag on bit 7, count in the low bits
		read_one(spi_hub_pkg::FIFO_STAT_ADDR, v);
		check_byte("fifo_stat", 8'h80 | DW'(DEPTH), v);
		// only the first DEPTH bytes were kept
		read_burst(spi_hub_pkg::FIFO_DATA_ADDR, DEPTH);
		for (int i = 0; i < DEPTH; i++) begin
			check_byte("fifo_data", sent[i], data_q[i]);
		end
		read_one(spi_hub_pkg::FIFO_STAT_ADDR, v);
		check_byte("fifo_stat", 8'h00, v);
		data_q.delete();
		repeat (3) data_q.push_back(DW'($random(seed)));
		write_burst(spi_hub_pkg::FIFO_DATA_ADDR);
		read_one(spi_hub_pkg::FIFO_STAT_ADDR, v);
		check_byte("fifo_stat", 8'h03, v);
		// fifo_clear is bit 1 of the control register
		write_one(spi_hub_pkg::CTRL_ADDR, 8'h02);
		read_one(spi_hub_pkg::FIFO_STAT_ADDR, v);
		check_byte("fifo_stat", 8'h00, v);
		read_one(spi_hub_pkg::CTRL_ADDR, v);
		check_byte("ctrl", 8'h00, v);
		finish_test("fifo full and clear", err0);
	endtask

	task automatic test_irq();
		int err0;
		logic [DW-1:0] v;
		logic [DW-1:0] b;
		err0 = err_cnt;
		b = DW'($random(seed));
		write_one(spi_hub_pkg::CTRL_ADDR, 8'h01);
		read_one(spi_hub_pkg::CTRL_ADDR, v);
		check_byte("ctrl", 8'h01, v);
		write_one(spi_hub_pkg::FIFO_DATA_ADDR, b);
		wait_irq(1'b1);
		read_one(spi_hub_pkg::FIFO_DATA_ADDR, v);
		check_byte("fifo_data", b, v);
		wait_irq(1'b0);
		// disabled, a stored byte must not raise irq
		write_one(spi_hub_pkg::CTRL_ADDR, 8'h00);
		write_one(spi_hub_pkg::FIFO_DATA_ADDR, b);
		repeat (8) @(negedge SPI_SCLK);
		check_bit("irq", 1'b0, irq);
		write_one(spi_hub_pkg::CTRL_ADDR, 8'h02);
		finish_test("interrupt", err0);
	endtask

	task automatic test_unmapped();
		int err0;
		logic [DW-1:0] v;
		err0 = err_cnt;
		read_one(7'h40, v);
		check_byte("unmapped", 8'h00, v);
		data_q.delete();
		repeat (3) data_q.push_back(DW'($random(seed)));
		write_burst(7'h40);
		// scratch still holds the earlier burst
		read_burst(spi_hub_pkg::SCRATCH_BASE, spi_hub_pkg::SCRATCH_N);
		foreach (scratch_model[i]) begin
			check_byte("scratch", scratch_model[i], data_q[i]);
		end
		finish_test("unmapped address", err0);
	endtask

	initial begin
		SPI_SCLK = 1'b0;
		int_rst_n = 1'b0;
		spi_ss_n = 1'b1;
		spi_mosi = 1'b0;
		seed = 32'h744ce971;
		err_cnt = 0;
		chk_cnt = 0;
		test_cnt = 0;
		repeat (8) @(negedge SPI_SCLK);
		int_rst_n = 1'b1;
		repeat (2) @(negedge SPI_SCLK);
		test_dev_id();
		test_scratch();
		test_fifo_burst();
		test_fifo_full();
		test_irq();
		test_unmapped();
		$display("%0d tests, %0d checks, %0d errors", test_cnt, chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	// overall run limit
	initial begin
		#1000000;
		$display("simulation ran past its time limit and was stopped");
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// ==== test/spi_hub_props.sv ====
//************************************************************
// SPI engine checks: strobe width, strobe exclusion and
// address stability while the target is deselected
//************************************************************
module spi_hub_props (
	input logic SPI_SCLK,
	input logic int_rst_n,
	input logic spi_ss_n,
	input logic wr_valid,
	input logic rd_ack,
	input logic [spi_hub_pkg::ADDR_W-1:0] addr
);
	timeunit 1ns;
	timeprecision 100ps;

	// strobes last a single cycle
	wr_pulse_a: assert property (@(posedge SPI_SCLK) disable iff (!int_rst_n)
		wr_valid |=> !wr_valid)
		else $error("wr_valid high on two consecutive edges");

	rd_pulse_a: assert property (@(posedge SPI_SCLK) disable iff (!int_rst_n)
		rd_ack |=> !rd_ack)
		else $error("rd_ack high on two consecutive edges");

	// a byte is either written or read, never both
	excl_a: assert property (@(posedge SPI_SCLK) disable iff (!int_rst_n)
		!(wr_valid && rd_ack))
		else $error("wr_valid and rd_ack high together");

	// deselected, only the trailing write strobe may step the address
	addr_hold_a: assert property (@(posedge SPI_SCLK) disable iff (!int_rst_n)
		(spi_ss_n && !wr_valid) |=> $stable(addr))
		else $error("address moved while spi_ss_n high");

endmodule

bind spi_slave spi_hub_props props0 (
	.SPI_SCLK  (SPI_SCLK),
	.int_rst_n (int_rst_n),
	.spi_ss_n  (spi_ss_n),
	.wr_valid  (wr_valid_q),
	.rd_ack    (rd_ack_q),
	.addr      (addr_q)
);

// ==== source/spi_hub.sv ====
//************************************************************
// sensor hub top: SPI engine, register bank and data FIFO
//************************************************************
module spi_hub #(
	parameter int FIFO_DEPTH = 8
) (
	input  logic SPI_SCLK,
	input  logic int_rst_n,
	input  logic spi_ss_n,
	input  logic spi_mosi,
	output logic spi_miso,
	output logic irq
);

	// register bank to fifo strobes and status
	logic fifo_push;
	logic fifo_pop;
	logic fifo_clear;
	logic [spi_hub_pkg::DATA_W-1:0] fifo_wdata;
	logic [spi_hub_pkg::DATA_W-1:0] fifo_head;
	logic [$clog2(FIFO_DEPTH):0] fifo_count;
	logic fifo_full;
	logic fifo_empty;

	// engine to register bank
	host_bus_if bus0 ();

	spi_slave slave0 (
		.SPI_SCLK  (SPI_SCLK),
		.int_rst_n (int_rst_n),
		.spi_ss_n  (spi_ss_n),
		.spi_mosi  (spi_mosi),
		.spi_miso  (spi_miso),
		.bus       (bus0.master)
	);

	reg_bank #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) regs0 (
		.SPI_SCLK   (SPI_SCLK),
		.int_rst_n  (int_rst_n),
		.bus        (bus0.target),
		.fifo_push  (fifo_push),
		.fifo_pop   (fifo_pop),
		.fifo_clear (fifo_clear),
		.fifo_wdata (fifo_wdata),
		.fifo_head  (fifo_head),
		.fifo_count (fifo_count),
		.fifo_full  (fifo_full),
		.fifo_empty (fifo_empty),
		.irq        (irq)
	);

	data_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) fifo0 (
		.SPI_SCLK  (SPI_SCLK),
		.int_rst_n (int_rst_n),
		.push      (fifo_push),
		.pop       (fifo_pop),
		.clear     (fifo_clear),
		.wdata     (fifo_wdata),
		.head      (fifo_head),
		.count     (fifo_count),
		.full      (fifo_full),
		.empty     (fifo_empty)
	);

endmodule

// ==== source/data_fifo.sv ====
//************************************************************
// byte FIFO on a circular buffer, push/pop/clear strobes,
// head shown combinationally
//************************************************************
module data_fifo #(
	parameter int FIFO_DEPTH = 8
) (
	input  logic SPI_SCLK,
	input  logic int_rst_n,
	input  logic push,
	input  logic pop,
	input  logic clear,
	input  logic [spi_hub_pkg::DATA_W-1:0] wdata,
	output logic [spi_hub_pkg::DATA_W-1:0] head,
	output logic [$clog2(FIFO_DEPTH):0] count,
	output logic full,
	output logic empty
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam logic [PTR_W:0] FULL_CNT = (PTR_W + 1)'(FIFO_DEPTH);

	logic [spi_hub_pkg::DATA_W-1:0] mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic do_push;
	logic do_pop;

	assign full = (count == FULL_CNT);
	assign empty = (count == '0);

	// push on full and pop on empty are dropped, clear wins
	assign do_push = push && !full && !clear;
	assign do_pop = pop && !empty && !clear;

	// storage
	always_ff @(posedge SPI_SCLK) begin
		if (do_push) begin
			mem[wr_ptr] <= wdata;
		end
	end

	// pointers wrap on their own, depth is a power of two
	always_ff @(posedge SPI_SCLK or negedge int_rst_n) begin
		if (!int_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else if (clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// both at once leaves the count alone
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

	assign head = mem[rd_ptr];

endmodule

// ==== source/reg_bank.sv ====
//************************************************************
// register bank: ID, control and scratch registers, fifo
// status, fifo data port steering and the interrupt level
//************************************************************
module reg_bank #(
	parameter int FIFO_DEPTH = 8
) (
	input  logic SPI_SCLK,
	input  logic int_rst_n,
	host_bus_if.target bus,
	output logic fifo_push,
	output logic fifo_pop,
	output logic fifo_clear,
	output logic [spi_hub_pkg::DATA_W-1:0] fifo_wdata,
	input  logic [spi_hub_pkg::DATA_W-1:0] fifo_head,
	input  logic [$clog2(FIFO_DEPTH):0] fifo_count,
	input  logic fifo_full,
	input  logic fifo_empty,
	output logic irq
);

	localparam int CNT_W = $clog2(FIFO_DEPTH) + 1;
	localparam int SCR_IDX_W = $clog2(spi_hub_pkg::SCRATCH_N);

	logic irq_en;
	logic [spi_hub_pkg::DATA_W-1:0] scratch [spi_hub_pkg::SCRATCH_N];
	logic is_scratch;
	logic [spi_hub_pkg::ADDR_W-1:0] scr_off;
	logic [SCR_IDX_W-1:0] scr_idx;
	logic at_fifo_port;
	logic [spi_hub_pkg::DATA_W-1:0] fifo_stat;

	// scratch window decode
	assign is_scratch = (bus.addr >= spi_hub_pkg::SCRATCH_BASE) &&
		(bus.addr <= spi_hub_pkg::SCRATCH_LAST);
	assign scr_off = bus.addr - spi_hub_pkg::SCRATCH_BASE;
	assign scr_idx = scr_off[SCR_IDX_W-1:0];
	assign at_fifo_port = (bus.addr == spi_hub_pkg::FIFO_DATA_ADDR);

	// fifo steering straight from the bus strobes
	assign fifo_push = bus.wr_valid && at_fifo_port;
	assign fifo_pop = bus.rd_ack && at_fifo_port;
	assign fifo_wdata = bus.wr_data;
	// wr_valid is one cycle wide so the clear is too
	assign fifo_clear = bus.wr_valid && (bus.addr == spi_hub_pkg::CTRL_ADDR) &&
		bus.wr_data[spi_hub_pkg::CTRL_FIFO_CLR_BIT];

	// register writes, ID, status and unmapped addresses drop them
	always_ff @(posedge SPI_SCLK or negedge int_rst_n) begin
		if (!int_rst_n) begin
			irq_en <= 1'b0;
			for (int i = 0; i < spi_hub_pkg::SCRATCH_N; i++) begin
				scratch[i] <= '0;
			end
		end else if (bus.wr_valid) begin
			if (bus.addr == spi_hub_pkg::CTRL_ADDR) begin
				irq_en <= bus.wr_data[spi_hub_pkg::CTRL_IRQ_EN_BIT];
			end
			if (is_scratch) begin
				scratch[scr_idx] <= bus.wr_data;
			end
		end
	end

	// count in the low bits, full flag on top
	always_comb begin
		fifo_stat = '0;
		fifo_stat[CNT_W-1:0] = fifo_count;
		fifo_stat[spi_hub_pkg::STAT_FULL_BIT] = fifo_full;
	end

	// read mux, purely a function of addr
	always_comb begin
		bus.rd_data = '0;
		if (bus.addr == spi_hub_pkg::DEV_ID_ADDR) begin
			bus.rd_data = spi_hub_pkg::DEVICE_ID;
		end else if (bus.addr == spi_hub_pkg::CTRL_ADDR) begin
			// clear bit always reads 0
			bus.rd_data[spi_hub_pkg::CTRL_IRQ_EN_BIT] = irq_en;
		end else if (is_scratch) begin
			bus.rd_data = scratch[scr_idx];
		end else if (bus.addr == spi_hub_pkg::FIFO_STAT_ADDR) begin
			bus.rd_data = fifo_stat;
		end else if (at_fifo_port) begin
			// stale head is hidden when there is nothing stored
			bus.rd_data = fifo_empty ? '0 : fifo_head;
		end
	end

	// level interrupt, follows fifo state one edge late
	always_ff @(posedge SPI_SCLK or negedge int_rst_n) begin
		if (!int_rst_n) begin
			irq <= 1'b0;
		end else begin
			irq <= irq_en && !fifo_empty;
		end
	end

endmodule

// ==== source/spi_slave.sv ====
//************************************************************
// mode 0 SPI target engine: command decode, burst address
// auto-increment, delayed write strobe and read acknowledge
//************************************************************
module spi_slave (
	input  logic SPI_SCLK,
	input  logic int_rst_n,
	input  logic spi_ss_n,
	input  logic spi_mosi,
	output logic spi_miso,
	host_bus_if.master bus
);

	localparam int BIT_W = $clog2(spi_hub_pkg::DATA_W);
	localparam logic [BIT_W-1:0] LAST_CNT = BIT_W'(spi_hub_pkg::DATA_W - 1);

	// mosi shifter and bit position within the current byte
	logic [spi_hub_pkg::DATA_W-1:0] shift_in;
	logic [BIT_W-1:0] bit_cnt;
	// rising edge that samples bit 0 of a byte
	logic last_bit;
	// high for one cycle after each complete byte
	logic rcv_byte_valid;

	// transaction state
	logic cmd_latched;
	logic is_write;
	spi_hub_pkg::spi_cmd_u cmd_in;
	logic [spi_hub_pkg::ADDR_W-1:0] addr_q;
	logic at_fifo_port;

	// write path
	logic wr_byte_done;
	logic [spi_hub_pkg::DATA_W-1:0] wr_data_q;
	logic write_pending;
	logic wr_valid_q;

	// read path
	logic rd_ack_q;
	logic [spi_hub_pkg::DATA_W-1:0] shift_out;

	// msb first, sampled on the rising edge
	always_ff @(posedge SPI_SCLK or negedge int_rst_n) begin
		if (!int_rst_n) begin
			shift_in <= '0;
			bit_cnt <= '0;
		end else if (spi_ss_n) begin
			// idle select restarts byte framing
			bit_cnt <= '0;
		end else begin
			shift_in <= {shift_in[spi_hub_pkg::DATA_W-2:0], spi_mosi};
			bit_cnt <= bit_cnt + 1'b1;
		end
	end

	assign last_bit = !spi_ss_n && (bit_cnt == LAST_CNT);

	always_ff @(posedge SPI_SCLK or negedge int_rst_n) begin
		if (!int_rst_n) begin
			rcv_byte_valid <= 1'b0;
		end else begin
			rcv_byte_valid <= last_bit;
		end
	end

	// shifter holds the full byte during the cycle after it completes
	assign cmd_in.raw = shift_in;

	// first byte of a transaction is the command
	always_ff @(posedge SPI_SCLK or negedge int_rst_n) begin
		if (!int_rst_n) begin
			cmd_latched <= 1'b0;
			is_write <= 1'b0;
		end else if (spi_ss_n) begin
			cmd_latched <= 1'b0;
		end else if (rcv_byte_valid && !cmd_latched) begin
			cmd_latched <= 1'b1;
			is_write <= cmd_in.f.wr;
		end
	end

	// data port keeps its address so bursts stay on the fifo
	assign at_fifo_port = (addr_q == spi_hub_pkg::FIFO_DATA_ADDR);

	// start address from the command, then step once per bus strobe
	always_ff @(posedge SPI_SCLK or negedge int_rst_n) begin
		if (!int_rst_n) begin
			addr_q <= '0;
		end else if (!spi_ss_n && rcv_byte_valid && !cmd_latched) begin
			addr_q <= cmd_in.f.addr;
		end else if ((wr_valid_q || rd_ack_q) && !at_fifo_port) begin
			addr_q <= addr_q + 1'b1;
		end
	end

	// every byte after the command carries write data
	assign wr_byte_done = last_bit && cmd_latched && is_write;

	// byte captured on its last bit, strobed out one edge later
	// so the write completes even if select is already released
	always_ff @(posedge SPI_SCLK or negedge int_rst_n) begin
		if (!int_rst_n) begin
			wr_data_q <= '0;
			write_pending <= 1'b0;
			wr_valid_q <= 1'b0;
		end else begin
			write_pending <= wr_byte_done;
			wr_valid_q <= write_pending;
			if (wr_byte_done) begin
				wr_data_q <= {shift_in[spi_hub_pkg::DATA_W-2:0], spi_mosi};
			end
		end
	end

	// ack each byte that follows the command on a read, the dummy
	// byte included, which moves on to the next prefetch
	// no ack once select is gone, the last prefetch was never sent
	always_ff @(posedge SPI_SCLK or negedge int_rst_n) begin
		if (!int_rst_n) begin
			rd_ack_q <= 1'b0;
		end else begin
			rd_ack_q <= !spi_ss_n && rcv_byte_valid && cmd_latched && !is_write;
		end
	end

	// miso side, falling edge
	// rcv_byte_valid is high on the falling edge that ends a byte,
	// load rd_data there for the byte that follows
	always_ff @(negedge SPI_SCLK or negedge int_rst_n) begin
		if (!int_rst_n) begin
			shift_out <= '0;
		end else if (rcv_byte_valid && cmd_latched && !is_write) begin
			shift_out <= bus.rd_data;
		end else begin
			shift_out <= {shift_out[spi_hub_pkg::DATA_W-2:0], 1'b0};
		end
	end

	assign spi_miso = shift_out[spi_hub_pkg::DATA_W-1];

	// register bus outputs
	assign bus.addr = addr_q;
	assign bus.wr_data = wr_data_q;
	assign bus.wr_valid = wr_valid_q;
	assign bus.rd_ack = rd_ack_q;

endmodule

// ==== source/host_bus_if.sv ====
//************************************************************
// internal register bus between the SPI engine and the
// register bank, plain strobes with no handshake
//************************************************************
interface host_bus_if;

	// register address, held across a burst
	logic [spi_hub_pkg::ADDR_W-1:0] addr;
	// write byte, valid with wr_valid
	logic [spi_hub_pkg::DATA_W-1:0] wr_data;
	// one-cycle write strobe
	logic wr_valid;
	// combinational read data, always follows addr
	logic [spi_hub_pkg::DATA_W-1:0] rd_data;
	// one-cycle read consumed strobe
	logic rd_ack;

	// spi engine side
	modport master (
		output addr,
		output wr_data,
		output wr_valid,
		output rd_ack,
		input  rd_data
	);

	// register bank side
	modport target (
		input  addr,
		input  wr_data,
		input  wr_valid,
		input  rd_ack,
		output rd_data
	);

endinterface

// ==== source/spi_hub_pkg.sv ====
//************************************************************
// spi_hub shared definitions: bus widths, register map,
// device ID and the SPI command byte layout
//************************************************************
package spi_hub_pkg;

	// register bus widths
	localparam int ADDR_W = 7;
	localparam int DATA_W = 8;

	// identification register, read only
	localparam logic [ADDR_W-1:0] DEV_ID_ADDR = 7'h00;
	localparam logic [DATA_W-1:0] DEVICE_ID = 8'hA5;

	// control register and its bits
	localparam logic [ADDR_W-1:0] CTRL_ADDR = 7'h01;
	localparam int CTRL_IRQ_EN_BIT = 0;
	// self-clearing, never reads back as 1
	localparam int CTRL_FIFO_CLR_BIT = 1;

	// plain scratch window
	localparam logic [ADDR_W-1:0] SCRATCH_BASE = 7'h02;
	localparam logic [ADDR_W-1:0] SCRATCH_LAST = 7'h0F;
	localparam int SCRATCH_N = SCRATCH_LAST - SCRATCH_BASE + 1;

	// fifo status (count in low bits, full flag on top) and data port
	localparam logic [ADDR_W-1:0] FIFO_STAT_ADDR = 7'h10;
	localparam int STAT_FULL_BIT = 7;
	localparam logic [ADDR_W-1:0] FIFO_DATA_ADDR = 7'h20;

	// command byte, msb is the direction (1 = write)
	typedef struct packed {
		logic wr;
		logic [ADDR_W-1:0] addr;
	} spi_cmd_t;

	// same byte seen raw off the shifter or split into fields
	typedef union packed {
		logic [DATA_W-1:0] raw;
		spi_cmd_t f;
	} spi_cmd_u;

endpackage
